//--- md_div_long.sv
// ----------------------------------------------------------
// Long divider for DIV and REM
// Absolute values, 31 compare-subtract steps, a last step
// and a final sign fix on the quotient or remainder
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_div_long (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  input  md_pkg::word_t op_a_i,
  input  md_pkg::word_t op_b_i,
  input  logic          is_rem_i,
  input  logic          sign_a_i,
  input  logic          sign_b_i,
  output md_pkg::word_t result_o,
  output logic          done_o
);

  import md_pkg::*;

  div_state_e        state_q, state_d;
  word_t             num_q, num_d;
  word_t             den_q, den_d;
  word_t             rem_q, rem_d;
  word_t             quot_q, quot_d;
  count_t            count_q, count_d;
  logic              done_q;
  logic [WORD_W:0]   sub_a;
  logic [WORD_W:0]   sub_b;
  logic [WORD_W:0]   sub_res;
  logic              rem_ge;
  word_t             next_rem;
  word_t             next_quot;
  word_t             one_shift;
  logic              div_change;
  logic              rem_change;

  // A borrow out of the shared subtractor means remainder below divisor
  assign sub_res = sub_a - sub_b;
  assign rem_ge  = ~sub_res[WORD_W];

  assign one_shift = {{(WORD_W-1){1'b0}}, 1'b1} << count_q;
  assign next_rem  = rem_ge ? sub_res[WORD_W-1:0] : rem_q;
  assign next_quot = rem_ge ? (quot_q | one_shift) : quot_q;

  // Quotient is negative for mixed signs and the remainder follows the dividend
  assign div_change = sign_a_i ^ sign_b_i;
  assign rem_change = sign_a_i;

  always_comb begin
    state_d = state_q;
    num_d   = num_q;
    den_d   = den_q;
    rem_d   = rem_q;
    quot_d  = quot_q;
    count_d = count_q;
    sub_a   = '0;
    sub_b   = {1'b0, op_b_i};

    unique case (state_q)
      DIV_IDLE: begin
        if (start_i) begin
          // Division by zero answers all ones for DIV and the dividend for REM
          rem_d = is_rem_i ? op_a_i : '1;
          // A zero divisor skips the sign fix entirely
          if (op_b_i == '0) begin
            state_d = DIV_FINISH;
          end else begin
            state_d = DIV_ABS_A;
          end
        end
      end

      DIV_ABS_A: begin
        sub_b   = {1'b0, op_a_i};
        num_d   = sign_a_i ? sub_res[WORD_W-1:0] : op_a_i;
        quot_d  = '0;
        state_d = DIV_ABS_B;
      end

      DIV_ABS_B: begin
        sub_b   = {1'b0, op_b_i};
        den_d   = sign_b_i ? sub_res[WORD_W-1:0] : op_b_i;
        rem_d   = {{(WORD_W-1){1'b0}}, num_q[WORD_W-1]};
        count_d = DIV_ITER_START;
        state_d = DIV_COMP;
      end

      DIV_COMP: begin
        sub_a   = {1'b0, rem_q};
        sub_b   = {1'b0, den_q};
        count_d = count_q - count_t'(1);
        // Shift the next dividend bit into the partial remainder
        rem_d   = {next_rem[WORD_W-2:0], num_q[count_d]};
        quot_d  = next_quot;
        if (count_q == count_t'(1)) begin
          state_d = DIV_LAST;
        end
      end

      DIV_LAST: begin
        sub_a   = {1'b0, rem_q};
        sub_b   = {1'b0, den_q};
        rem_d   = is_rem_i ? next_rem : next_quot;
        state_d = DIV_CHANGE_SIGN;
      end

      DIV_CHANGE_SIGN: begin
        sub_b = {1'b0, rem_q};
        if (is_rem_i ? rem_change : div_change) begin
          rem_d = sub_res[WORD_W-1:0];
        end
        state_d = DIV_FINISH;
      end

      DIV_FINISH: begin
        state_d = DIV_IDLE;
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      done_q  <= (state_q == DIV_FINISH);
    end
  end

  always_ff @(posedge clk_i) begin
    num_q  <= num_d;
    den_q  <= den_d;
    rem_q  <= rem_d;
    quot_q <= quot_d;
  end

  // Final word sits in the remainder register from the sign fix onward
  assign result_o = rem_q;
  assign done_o   = done_q;

endmodule

//--- md_mult_iter.sv
// ----------------------------------------------------------
// Iterative multiplier for MUL and MULH
// One 17x17 signed multiply-accumulate per cycle over the
// four 16-bit partial products
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_mult_iter (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  input  md_pkg::word_t op_a_i,
  input  md_pkg::word_t op_b_i,
  input  logic          is_high_i,
  input  logic          sign_a_i,
  input  logic          sign_b_i,
  input  logic          signed_mult_i,
  output md_pkg::word_t result_o,
  output logic          done_o
);

  import md_pkg::*;

  mult_state_e state_q, state_d;
  half_t       mult_op_a;
  half_t       mult_op_b;
  logic        mac_sign_a;
  logic        mac_sign_b;
  acc_t        accum;
  acc_t        mac_res;
  acc_t        acc_q, acc_d;
  logic        step;
  logic        fin;
  word_t       fin_word;
  word_t       result_q;
  logic        done_q;

  // Top two bits of the exact sum always agree, so 34 bits hold it
  assign mac_res = $signed({mac_sign_a, mult_op_a}) * $signed({mac_sign_b, mult_op_b})
                 + $signed(accum);

  // ALBL waits for a start, every other state advances each cycle
  assign step = (state_q != ALBL) | start_i;

  always_comb begin
    mult_op_a  = op_a_i[HALF_W-1:0];
    mult_op_b  = op_b_i[HALF_W-1:0];
    mac_sign_a = 1'b0;
    mac_sign_b = 1'b0;
    accum      = '0;
    acc_d      = acc_q;
    state_d    = state_q;
    fin        = 1'b0;
    fin_word   = mac_res[WORD_W-1:0];

    unique case (state_q)
      ALBL: begin
        acc_d = mac_res;
        if (start_i) begin
          state_d = ALBH;
        end
      end

      ALBH: begin
        mult_op_b  = op_b_i[WORD_W-1:HALF_W];
        mac_sign_b = sign_b_i;
        // Low by low product is unsigned and carries nothing
        accum      = {18'b0, acc_q[WORD_W-1:HALF_W]};
        if (is_high_i) begin
          acc_d = mac_res;
        end else begin
          acc_d = {2'b0, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        mult_op_a  = op_a_i[WORD_W-1:HALF_W];
        mac_sign_a = sign_a_i;
        if (is_high_i) begin
          accum   = acc_q;
          acc_d   = mac_res;
          state_d = AHBH;
        end else begin
          accum    = {18'b0, acc_q[WORD_W-1:HALF_W]};
          fin      = 1'b1;
          fin_word = {mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
          state_d  = ALBL;
        end
      end

      AHBH: begin
        mult_op_a  = op_a_i[WORD_W-1:HALF_W];
        mult_op_b  = op_b_i[WORD_W-1:HALF_W];
        mac_sign_a = sign_a_i;
        mac_sign_b = sign_b_i;
        // Carry in the upper word, sign extended for any signed mode
        accum      = {{16{signed_mult_i & acc_q[WORD_W+1]}}, acc_q[WORD_W+1:HALF_W]};
        fin        = 1'b1;
        state_d    = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= fin;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step) begin
      acc_q <= acc_d;
    end
    if (fin) begin
      result_q <= fin_word;
    end
  end

  assign result_o = result_q;
  assign done_o   = done_q;

endmodule

//--- md_operand_ctrl.sv
// ----------------------------------------------------------
// Operand capture and operator decode
// Holds the operation stable for the engines and tracks busy
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_operand_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_pkg::md_op_e      operator_i,
  input  md_pkg::sign_mode_t  signed_mode_i,
  input  md_pkg::word_t       op_a_i,
  input  md_pkg::word_t       op_b_i,
  input  logic                result_taken_i,
  output md_pkg::word_t       op_a_o,
  output md_pkg::word_t       op_b_o,
  output md_pkg::md_op_e      operator_o,
  output logic                sign_a_o,
  output logic                sign_b_o,
  output logic                signed_mult_o,
  output logic                mult_start_o,
  output logic                div_start_o,
  output logic                busy_o
);

  import md_pkg::*;

  logic   accept;
  logic   is_mult_op;
  word_t  op_a_q;
  word_t  op_b_q;
  md_op_e operator_q;
  logic   sign_a_q;
  logic   sign_b_q;
  logic   signed_mult_q;
  logic   mult_start_q;
  logic   div_start_q;
  logic   busy_q;

  // Requests arriving while an operation is in flight are dropped
  assign accept     = start_i & ~busy_q;
  assign is_mult_op = (operator_i == MD_OP_MULL) | (operator_i == MD_OP_MULH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_start_q <= 1'b0;
      div_start_q  <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      mult_start_q <= accept & is_mult_op;
      div_start_q  <= accept & ~is_mult_op;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (result_taken_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operand signs are derived once here and shared by both engines
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_a_q        <= op_a_i;
      op_b_q        <= op_b_i;
      operator_q    <= operator_i;
      sign_a_q      <= signed_mode_i[0] & op_a_i[WORD_W-1];
      sign_b_q      <= signed_mode_i[1] & op_b_i[WORD_W-1];
      signed_mult_q <= |signed_mode_i;
    end
  end

  assign op_a_o        = op_a_q;
  assign op_b_o        = op_b_q;
  assign operator_o    = operator_q;
  assign sign_a_o      = sign_a_q;
  assign sign_b_o      = sign_b_q;
  assign signed_mult_o = signed_mult_q;
  assign mult_start_o  = mult_start_q;
  assign div_start_o   = div_start_q;
  assign busy_o        = busy_q;

endmodule

//--- md_pkg.sv
// ----------------------------------------------------------
// RV32M multiply and divide unit shared definitions
// Widths, operator and state encodings, divider constants
// ----------------------------------------------------------

package md_pkg;

  // Data widths
  localparam int unsigned WORD_W = 32;
  localparam int unsigned HALF_W = 16;

  // Operand and result word
  typedef logic [WORD_W-1:0] word_t;

  // One half of an operand as fed to the 17x17 multiplier
  typedef logic [HALF_W-1:0] half_t;

  // Partial sum with room for carry and sign
  typedef logic [WORD_W+1:0] acc_t;

  // Divider iteration counter
  typedef logic [4:0] count_t;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  typedef logic [1:0] sign_mode_t;

  // Counter load value for the 31 compare steps
  localparam count_t DIV_ITER_START = 5'd31;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Partial product being accumulated
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_CHANGE_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

//--- md_result_out.sv
// ----------------------------------------------------------
// Result register of the multiply and divide unit
// Captures the finishing engine's word and pulses valid
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_result_out (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          mult_done_i,
  input  md_pkg::word_t mult_result_i,
  input  logic          div_done_i,
  input  md_pkg::word_t div_result_i,
  output md_pkg::word_t result_o,
  output logic          valid_o,
  output logic          result_taken_o
);

  import md_pkg::*;

  logic  done_any;
  word_t result_q;
  logic  valid_q;

  // Only one engine runs at a time
  assign done_any = mult_done_i | div_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= done_any;
    end
  end

  // Word stays here until the next operation completes
  always_ff @(posedge clk_i) begin
    if (done_any) begin
      result_q <= mult_done_i ? mult_result_i : div_result_i;
    end
  end

  assign result_o       = result_q;
  assign valid_o        = valid_q;
  assign result_taken_o = done_any;

endmodule

//--- md_tb_tasks.svh
// ----------------------------------------------------------
// Testbench tasks for the multiply and divide unit
// Operand source, reference model, drive and compare tasks
// ----------------------------------------------------------

`ifndef MD_TB_TASKS_SVH
`define MD_TB_TASKS_SVH

// Galois LFSR stepped once for every bit taken
function automatic word_t rand_bits(input int unsigned n);
  word_t       bits;
  int unsigned i;
  bits = '0;
  for (i = 0; i < n; i++) begin
    bits = {bits[WORD_W-2:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
  end
  return bits;
endfunction

// Low or high word of the full 64-bit product
function automatic word_t ref_mul(input md_op_e op, input sign_mode_t mode,
                                  input word_t a, input word_t b);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] prod;
  ext_a = mode[0] ? {{32{a[31]}}, a} : {32'b0, a};
  ext_b = mode[1] ? {{32{b[31]}}, b} : {32'b0, b};
  // Product modulo 2^64 is exact for any mix of 33-bit operands
  prod = ext_a * ext_b;
  return (op == MD_OP_MULH) ? prod[63:32] : prod[31:0];
endfunction

// RISC-V M division with mode 2'b11 signed and 2'b00 unsigned
function automatic word_t ref_div(input md_op_e op, input sign_mode_t mode,
                                  input word_t a, input word_t b);
  int    sa;
  int    sb;
  word_t res;
  sa = a;
  sb = b;
  if (b == '0) begin
    res = (op == MD_OP_REM) ? a : '1;
  end else if (mode == 2'b11 && a == 32'h8000_0000 && b == '1) begin
    res = (op == MD_OP_REM) ? '0 : a;
  end else if (mode == 2'b11) begin
    // Truncation toward zero and a remainder that follows the dividend
    res = (op == MD_OP_REM) ? word_t'(sa % sb) : word_t'(sa / sb);
  end else begin
    res = (op == MD_OP_REM) ? (a % b) : (a / b);
  end
  return res;
endfunction

function automatic int unsigned expected_latency(input md_op_e op, input word_t b);
  if (op == MD_OP_MULL) begin
    return LAT_MULL;
  end else if (op == MD_OP_MULH) begin
    return LAT_MULH;
  end
  return (b == '0) ? LAT_DIV_ZERO : LAT_DIV;
endfunction

task automatic abort_run();
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// Called on a falling edge so the next rising edge samples the request
task automatic drive_start(input md_op_e op, input sign_mode_t mode,
                           input word_t a, input word_t b);
  start_i       = 1'b1;
  operator_i    = op;
  signed_mode_i = mode;
  op_a_i        = a;
  op_b_i        = b;
endtask

// Counts falling edges from the sampling edge until valid_o shows up
task automatic wait_valid(input int unsigned exp_lat, input int unsigned first_cyc);
  int unsigned cyc;
  logic        seen;
  cyc  = first_cyc;
  seen = 1'b0;
  while (!seen) begin
    @(negedge clk_i);
    start_i = 1'b0;
    if (valid_o === 1'b1) begin
      seen = 1'b1;
    end else begin
      check_bit("busy_o", busy_o, 1'b1);
      if (have_result) begin
        check_word("result_o while busy", result_o, last_result);
      end
      if (cyc > exp_lat) begin
        $display("No valid_o pulse within %0d cycles after start", cyc);
        abort_run();
      end
      cyc++;
    end
  end
  if (cyc != exp_lat) begin
    $display("valid_o rose %0d cycles after start instead of %0d", cyc, exp_lat);
    abort_run();
  end
  // Busy drops in the valid cycle so a new start can follow at once
  check_bit("busy_o in valid cycle", busy_o, 1'b0);
endtask

task automatic record_result(input md_op_e op, input sign_mode_t mode,
                             input word_t a, input word_t b, input word_t exp);
  check_word($sformatf("result_o %s mode %0d a 0x%08h b 0x%08h", op.name(), mode, a, b),
             result_o, exp);
  last_result = exp;
  have_result = 1'b1;
endtask

task automatic run_op(input md_op_e op, input sign_mode_t mode,
                      input word_t a, input word_t b);
  word_t exp;
  if (op == MD_OP_DIV || op == MD_OP_REM) begin
    exp = ref_div(op, mode, a, b);
  end else begin
    exp = ref_mul(op, mode, a, b);
  end
  drive_start(op, mode, a, b);
  wait_valid(expected_latency(op, b), 0);
  record_result(op, mode, a, b, exp);
endtask

task automatic idle_cycles(input int unsigned n);
  int unsigned i;
  for (i = 0; i < n; i++) begin
    @(negedge clk_i);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    if (have_result) begin
      check_word("result_o while idle", result_o, last_result);
    end
  end
endtask

`endif

//--- md_tb.sv
// ----------------------------------------------------------
// Testbench for the RV32M multiply and divide unit
// Directed tests against a RISC-V M reference model
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_tb;

  import md_pkg::*;

  localparam word_t       LFSR_SEED    = 32'h0000_f6a8;
  localparam word_t       LFSR_TAPS    = 32'h8020_0003;
  localparam int unsigned LAT_MULL     = 4;
  localparam int unsigned LAT_MULH     = 5;
  localparam int unsigned LAT_DIV      = 38;
  localparam int unsigned LAT_DIV_ZERO = 3;

  // Corner products, random products, random divides, zero divisors,
  // overflow cases, ignored starts and back-to-back runs
  localparam int unsigned NUM_OPS        = 200 + 16 + 48 + 20 + 4 + 2 + 4;
  localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_OPS + 100;

  localparam word_t CORNERS [5] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff
  };

  logic        clk_i;
  logic        rst_ni;
  logic        start_i;
  md_op_e      operator_i;
  sign_mode_t  signed_mode_i;
  word_t       op_a_i;
  word_t       op_b_i;
  word_t       result_o;
  logic        valid_o;
  logic        busy_o;

  word_t       lfsr_state;
  word_t       last_result;
  logic        have_result;
  int unsigned cycle_count = 0;

  md_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (result_o),
    .valid_o       (valid_o),
    .busy_o        (busy_o)
  );

  `include "md_tb_tasks.svh"

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run took more than %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic test_mul_corners();
    int unsigned m;
    int unsigned i;
    int unsigned j;
    for (m = 0; m < 4; m++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          run_op(MD_OP_MULL, sign_mode_t'(m), CORNERS[i], CORNERS[j]);
          run_op(MD_OP_MULH, sign_mode_t'(m), CORNERS[i], CORNERS[j]);
        end
      end
    end
  endtask

  task automatic test_mul_random();
    int unsigned k;
    sign_mode_t  mode;
    word_t       a;
    word_t       b;
    for (k = 0; k < 8; k++) begin
      mode = sign_mode_t'(rand_bits(2));
      a    = rand_bits(32);
      b    = rand_bits(32);
      run_op(MD_OP_MULL, mode, a, b);
      run_op(MD_OP_MULH, mode, a, b);
    end
  endtask

  task automatic test_div_random();
    int unsigned k;
    word_t       a;
    word_t       b;
    for (k = 0; k < 12; k++) begin
      a = rand_bits(32);
      // Random shift gives small divisors and larger quotients
      b = rand_bits(32) >> rand_bits(5);
      run_op(MD_OP_DIV, 2'b11, a, b);
      run_op(MD_OP_REM, 2'b11, a, b);
      run_op(MD_OP_DIV, 2'b00, a, b);
      run_op(MD_OP_REM, 2'b00, a, b);
    end
  endtask

  task automatic test_div_by_zero();
    int unsigned i;
    for (i = 0; i < 5; i++) begin
      run_op(MD_OP_DIV, 2'b11, CORNERS[i], '0);
      run_op(MD_OP_REM, 2'b11, CORNERS[i], '0);
      run_op(MD_OP_DIV, 2'b00, CORNERS[i], '0);
      run_op(MD_OP_REM, 2'b00, CORNERS[i], '0);
    end
  endtask

  task automatic test_div_overflow();
    run_op(MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    run_op(MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    run_op(MD_OP_DIV, 2'b00, 32'h8000_0000, 32'hffff_ffff);
    run_op(MD_OP_REM, 2'b00, 32'h8000_0000, 32'hffff_ffff);
  endtask

  // Second request arrives one cycle into the first operation
  task automatic run_with_intruder(input md_op_e op, input sign_mode_t mode,
                                   input word_t a, input word_t b, input md_op_e other_op);
    word_t exp;
    if (op == MD_OP_DIV || op == MD_OP_REM) begin
      exp = ref_div(op, mode, a, b);
    end else begin
      exp = ref_mul(op, mode, a, b);
    end
    drive_start(op, mode, a, b);
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b1);
    drive_start(other_op, 2'b00, ~a, '0);
    wait_valid(expected_latency(op, b), 1);
    record_result(op, mode, a, b, exp);
  endtask

  task automatic test_busy_ignore();
    run_with_intruder(MD_OP_MULH, 2'b11, 32'h1234_5678, 32'h9abc_def0, MD_OP_DIV);
    idle_cycles(2);
    run_with_intruder(MD_OP_REM, 2'b11, 32'hf000_0013, 32'h0000_0005, MD_OP_MULL);
  endtask

  task automatic test_back_to_back();
    run_op(MD_OP_MULL, 2'b00, 32'h0001_0003, 32'h0002_0005);
    run_op(MD_OP_DIV, 2'b11, 32'hffff_ff9c, 32'h0000_0007);
    run_op(MD_OP_MULH, 2'b01, 32'hdead_beef, 32'hcafe_f00d);
    run_op(MD_OP_REM, 2'b00, 32'hdead_beef, 32'h0000_1000);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = '0;
    op_a_i        = '0;
    op_b_i        = '0;
    lfsr_state    = LFSR_SEED;
    last_result   = '0;
    have_result   = 1'b0;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Nothing may come out before the first request
    idle_cycles(3);
    test_mul_corners();
    idle_cycles(2);
    test_mul_random();
    idle_cycles(2);
    test_div_random();
    idle_cycles(2);
    test_div_by_zero();
    idle_cycles(2);
    test_div_overflow();
    idle_cycles(2);
    test_busy_ignore();
    test_back_to_back();
    idle_cycles(2);

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- md_top.sv
// ----------------------------------------------------------
// RV32M multiply and divide unit
// Operand capture, multiplier and divider engines, result
// ----------------------------------------------------------

`timescale 1ns/1ps

module md_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  md_pkg::md_op_e     operator_i,
  input  md_pkg::sign_mode_t signed_mode_i,
  input  md_pkg::word_t      op_a_i,
  input  md_pkg::word_t      op_b_i,
  output md_pkg::word_t      result_o,
  output logic               valid_o,
  output logic               busy_o
);

  import md_pkg::*;

  word_t  op_a;
  word_t  op_b;
  md_op_e operator;
  logic   sign_a;
  logic   sign_b;
  logic   signed_mult;
  logic   mult_start;
  logic   div_start;
  word_t  mult_result;
  logic   mult_done;
  word_t  div_result;
  logic   div_done;
  logic   result_taken;

  md_operand_ctrl operand_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .operator_i     (operator_i),
    .signed_mode_i  (signed_mode_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .result_taken_i (result_taken),
    .op_a_o         (op_a),
    .op_b_o         (op_b),
    .operator_o     (operator),
    .sign_a_o       (sign_a),
    .sign_b_o       (sign_b),
    .signed_mult_o  (signed_mult),
    .mult_start_o   (mult_start),
    .div_start_o    (div_start),
    .busy_o         (busy_o)
  );

  md_mult_iter mult_iter_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (mult_start),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .is_high_i     (operator == MD_OP_MULH),
    .sign_a_i      (sign_a),
    .sign_b_i      (sign_b),
    .signed_mult_i (signed_mult),
    .result_o      (mult_result),
    .done_o        (mult_done)
  );

  md_div_long div_long_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .is_rem_i (operator == MD_OP_REM),
    .sign_a_i (sign_a),
    .sign_b_i (sign_b),
    .result_o (div_result),
    .done_o   (div_done)
  );

  md_result_out result_out_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mult_done_i    (mult_done),
    .mult_result_i  (mult_result),
    .div_done_i     (div_done),
    .div_result_i   (div_result),
    .result_o       (result_o),
    .valid_o        (valid_o),
    .result_taken_o (result_taken)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the multiply and divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -Wno-fatal --top-module md_tb -f sources.f -o md_tb_sim \
  && ./obj_dir/md_tb_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log 2>/dev/null \
  && echo "Result: passed" \
  || { echo "Result: failed"; exit 1; }

//--- sources.f
+incdir+.
md_pkg.sv
md_operand_ctrl.sv
md_mult_iter.sv
md_div_long.sv
md_result_out.sv
md_top.sv
md_tb.sv
